//--- verilog/fetch_pkg.sv
package fetch_pkg;

   // first fetch address out of reset
   localparam logic [63:0] reset_pc = 64'h0000_0000_8000_0000;

   // datapath widths
   localparam int xlen = 64;
   localparam int inst_w = 32;
   localparam logic [xlen-1:0] pc_step = 4;

   // rv opcode fields used by the predictor
   localparam logic [6:0] opc_jal = 7'b1101111;
   localparam logic [6:0] opc_branch = 7'b1100011;

   // direct-mapped geometry, one line is four 64-bit beats
   localparam int line_bytes = 32;
   localparam int line_count = 16;
   localparam int off_w = $clog2(line_bytes);
   localparam int idx_w = $clog2(line_count);
   localparam int tag_w = xlen - off_w - idx_w;
   localparam int beat_count = line_bytes / 8;
   localparam int beat_w = $clog2(beat_count);
   // lowest pc bit of the beat number
   localparam int beat_lsb = off_w - beat_w;
   // picks the upper instruction in a beat
   localparam int half_bit = beat_lsb - 1;

   // read burst fields
   localparam logic [7:0] burst_len = 8'd3;
   localparam logic [2:0] burst_size = 3'd3;
   localparam logic [1:0] burst_incr = 2'd1;

   // decode buffer slots
   localparam int if_id_credits = 2;
   localparam int credit_w = $clog2(if_id_credits + 1);
   localparam logic [credit_w-1:0] credit_init = credit_w'(if_id_credits);

   typedef enum logic [1:0] {op_jal, op_branch, op_other} opcode_e;

   typedef enum logic [1:0] {st_idle, st_addr, st_data} refill_state_e;

endpackage

//--- verilog/fetch_unit.sv
module fetch_unit (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          redirect,
   input  logic [fetch_pkg::xlen-1:0]    redirect_pc,
   input  logic                          credit_return,
   input  logic                          req_ready,
   input  logic                          resp_valid,
   input  logic [fetch_pkg::inst_w-1:0]  resp_inst,
   input  logic [fetch_pkg::xlen-1:0]    resp_pc,
   output logic                          inst_valid,
   output logic [fetch_pkg::inst_w-1:0]  inst,
   output logic [fetch_pkg::xlen-1:0]    inst_pc,
   output logic                          req_valid,
   output logic [fetch_pkg::xlen-1:0]    req_pc,
   output logic                          flush
);

   // pc of the next request still to be issued
   logic [fetch_pkg::xlen-1:0] pc_q;
   // one request outstanding in the cache
   logic pending_q;
   logic [fetch_pkg::credit_w-1:0] credit_cnt;

   fetch_pkg::opcode_e opc;
   logic [fetch_pkg::xlen-1:0] imm_b;
   logic [fetch_pkg::xlen-1:0] imm_j;
   logic [fetch_pkg::xlen-1:0] pred_pc;
   logic slot_free;
   logic has_credit;
   logic req_fire;

   // redirect kills everything in flight
   assign flush = redirect;

   // hit data goes straight to decode
   assign inst_valid = resp_valid && !redirect;
   assign inst = resp_inst;
   assign inst_pc = resp_pc;

   // opcode class of the returned word
   always_comb begin
      unique case (resp_inst[6:0])
         fetch_pkg::opc_jal:    opc = fetch_pkg::op_jal;
         fetch_pkg::opc_branch: opc = fetch_pkg::op_branch;
         default:               opc = fetch_pkg::op_other;
      endcase
   end

   // b-type and j-type offsets, sign extended
   assign imm_b = {{(fetch_pkg::xlen-13){resp_inst[31]}}, resp_inst[31], resp_inst[7],
                   resp_inst[30:25], resp_inst[11:8], 1'b0};
   assign imm_j = {{(fetch_pkg::xlen-21){resp_inst[31]}}, resp_inst[31], resp_inst[19:12],
                   resp_inst[20], resp_inst[30:21], 1'b0};

   // static prediction
   // jal always taken, branch taken only when backward
   always_comb begin
      if (opc == fetch_pkg::op_jal) begin
         pred_pc = resp_pc + imm_j;
      end else if (opc == fetch_pkg::op_branch && resp_inst[31]) begin
         pred_pc = resp_pc + imm_b;
      end else begin
         pred_pc = resp_pc + fetch_pkg::pc_step;
      end
   end

   // next request may go out once the current one answers
   assign slot_free = !pending_q || resp_valid;
   // keep a slot for the answer, net of what decode takes this cycle
   assign has_credit = inst_valid ? (credit_cnt > 1) : (credit_cnt != 0);

   assign req_valid = slot_free && has_credit && !redirect;
   // follow the predicted path in the same cycle as the hit
   assign req_pc = resp_valid ? pred_pc : pc_q;
   assign req_fire = req_valid && req_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q <= fetch_pkg::reset_pc;
         pending_q <= 1'b0;
         credit_cnt <= fetch_pkg::credit_init;
      end else begin
         // redirect first, then predicted successor, else hold
         if (redirect) begin
            pc_q <= redirect_pc;
         end else if (resp_valid) begin
            pc_q <= pred_pc;
         end

         if (redirect) begin
            pending_q <= 1'b0;
         end else if (req_fire) begin
            pending_q <= 1'b1;
         end else if (resp_valid) begin
            pending_q <= 1'b0;
         end

         // one slot per delivered word, one back per return pulse
         unique case ({inst_valid, credit_return})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   // decode never returns more slots than it owns
   a_credit_max: assert property (@(posedge clk) disable iff (rst)
      credit_cnt <= fetch_pkg::if_id_credits)
      else $error("credit counter above decode depth");

   // the reserved slot is still there when the answer lands
   a_credit_avail: assert property (@(posedge clk) disable iff (rst)
      inst_valid |-> credit_cnt != 0)
      else $error("inst_valid with no decode credit");

endmodule

//--- verilog/icache.sv
module icache (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          flush,
   input  logic                          req_valid,
   input  logic [fetch_pkg::xlen-1:0]    req_pc,
   input  logic                          arready,
   input  logic [fetch_pkg::xlen-1:0]    rdata,
   input  logic                          rvalid,
   input  logic                          rlast,
   output logic                          req_ready,
   output logic                          resp_valid,
   output logic [fetch_pkg::inst_w-1:0]  resp_inst,
   output logic [fetch_pkg::xlen-1:0]    resp_pc,
   output logic [fetch_pkg::xlen-1:0]    araddr,
   output logic [7:0]                    arlen,
   output logic [2:0]                    arsize,
   output logic [1:0]                    arburst,
   output logic                          arvalid,
   output logic                          rready
);

   // tag, data and valid arrays
   logic [fetch_pkg::tag_w-1:0] tag_mem [fetch_pkg::line_count];
   logic [fetch_pkg::xlen-1:0] data_mem [fetch_pkg::line_count * fetch_pkg::beat_count];
   logic [fetch_pkg::line_count-1:0] line_valid;

   fetch_pkg::refill_state_e state;
   logic [fetch_pkg::beat_w-1:0] beat_cnt;
   // cleared by flush, the refill then ends silently
   logic keep_resp;

   logic [fetch_pkg::idx_w-1:0] req_idx;
   logic [fetch_pkg::beat_w-1:0] req_beat;
   logic [fetch_pkg::tag_w-1:0] req_tag;
   logic [fetch_pkg::xlen-1:0] hit_word;
   logic hit;
   logic fire;

   // refill target comes from the pc held for the answer
   logic [fetch_pkg::idx_w-1:0] fill_idx;
   logic [fetch_pkg::beat_w-1:0] fill_beat;
   logic [fetch_pkg::tag_w-1:0] fill_tag;

   function automatic logic [fetch_pkg::inst_w-1:0] pick_half(
      input logic [fetch_pkg::xlen-1:0] word,
      input logic upper
   );
      return upper ? word[fetch_pkg::inst_w +: fetch_pkg::inst_w]
                   : word[0 +: fetch_pkg::inst_w];
   endfunction

   // pc split
   assign req_idx = req_pc[fetch_pkg::off_w +: fetch_pkg::idx_w];
   assign req_beat = req_pc[fetch_pkg::beat_lsb +: fetch_pkg::beat_w];
   assign req_tag = req_pc[fetch_pkg::xlen-1 -: fetch_pkg::tag_w];

   assign fill_idx = resp_pc[fetch_pkg::off_w +: fetch_pkg::idx_w];
   assign fill_beat = resp_pc[fetch_pkg::beat_lsb +: fetch_pkg::beat_w];
   assign fill_tag = resp_pc[fetch_pkg::xlen-1 -: fetch_pkg::tag_w];

   // lookup in the accept cycle
   assign hit_word = data_mem[{req_idx, req_beat}];
   assign hit = line_valid[req_idx] && (tag_mem[req_idx] == req_tag);

   // blocked for the whole refill
   assign req_ready = (state == fetch_pkg::st_idle);
   assign fire = req_valid && req_ready;

   // fixed burst shape, one whole line
   assign arlen = fetch_pkg::burst_len;
   assign arsize = fetch_pkg::burst_size;
   assign arburst = fetch_pkg::burst_incr;
   assign rready = (state == fetch_pkg::st_data);

   // refill fsm and response strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= fetch_pkg::st_idle;
         arvalid <= 1'b0;
         resp_valid <= 1'b0;
         keep_resp <= 1'b0;
         beat_cnt <= '0;
         line_valid <= '0;
      end else begin
         resp_valid <= 1'b0;
         if (flush) begin
            keep_resp <= 1'b0;
         end
         unique case (state)
            fetch_pkg::st_idle: begin
               if (fire && hit) begin
                  resp_valid <= !flush;
               end else if (fire) begin
                  // miss, go fetch the line
                  state <= fetch_pkg::st_addr;
                  arvalid <= 1'b1;
                  keep_resp <= !flush;
               end
            end
            fetch_pkg::st_addr: begin
               if (arready) begin
                  state <= fetch_pkg::st_data;
                  arvalid <= 1'b0;
                  beat_cnt <= '0;
               end
            end
            fetch_pkg::st_data: begin
               if (rvalid) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (rlast) begin
                     // line complete, answer next cycle unless flushed
                     state <= fetch_pkg::st_idle;
                     line_valid[fill_idx] <= 1'b1;
                     resp_valid <= keep_resp && !flush;
                  end
               end
            end
            default: state <= fetch_pkg::st_idle;
         endcase
      end
   end

   // arrays and response payload
   always_ff @(posedge clk) begin
      if (fire) begin
         resp_pc <= req_pc;
         araddr <= {req_pc[fetch_pkg::xlen-1:fetch_pkg::off_w], {fetch_pkg::off_w{1'b0}}};
         if (hit) begin
            resp_inst <= pick_half(hit_word, req_pc[fetch_pkg::half_bit]);
         end
      end
      if (rready && rvalid) begin
         data_mem[{fill_idx, beat_cnt}] <= rdata;
         // grab the waiting word as it streams past
         if (beat_cnt == fill_beat) begin
            resp_inst <= pick_half(rdata, resp_pc[fetch_pkg::half_bit]);
         end
         if (rlast) begin
            tag_mem[fill_idx] <= fill_tag;
         end
      end
   end

   // burst address always on a line boundary
   a_ar_aligned: assert property (@(posedge clk) disable iff (rst)
      arvalid |-> araddr[fetch_pkg::off_w-1:0] == '0)
      else $error("araddr not line aligned");

   // address phase only in its own state
   a_ar_state: assert property (@(posedge clk) disable iff (rst)
      arvalid |-> state == fetch_pkg::st_addr)
      else $error("arvalid outside address state");

endmodule

//--- verilog/fetch_top.sv
module fetch_top (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          redirect,
   input  logic [fetch_pkg::xlen-1:0]    redirect_pc,
   input  logic                          credit_return,
   output logic                          inst_valid,
   output logic [fetch_pkg::inst_w-1:0]  inst,
   output logic [fetch_pkg::xlen-1:0]    inst_pc,
   output logic [fetch_pkg::xlen-1:0]    araddr,
   output logic [7:0]                    arlen,
   output logic [2:0]                    arsize,
   output logic [1:0]                    arburst,
   output logic                          arvalid,
   input  logic                          arready,
   input  logic [fetch_pkg::xlen-1:0]    rdata,
   input  logic                          rvalid,
   input  logic                          rlast,
   output logic                          rready
);

   // fetch to cache request and answer
   logic req_valid;
   logic req_ready;
   logic [fetch_pkg::xlen-1:0] req_pc;
   logic resp_valid;
   logic [fetch_pkg::inst_w-1:0] resp_inst;
   logic [fetch_pkg::xlen-1:0] resp_pc;
   logic flush;

   fetch_unit i_fetch_unit (
      .clk           (clk),
      .rst           (rst),
      .redirect      (redirect),
      .redirect_pc   (redirect_pc),
      .credit_return (credit_return),
      .req_ready     (req_ready),
      .resp_valid    (resp_valid),
      .resp_inst     (resp_inst),
      .resp_pc       (resp_pc),
      .inst_valid    (inst_valid),
      .inst          (inst),
      .inst_pc       (inst_pc),
      .req_valid     (req_valid),
      .req_pc        (req_pc),
      .flush         (flush)
   );

   icache i_icache (
      .clk        (clk),
      .rst        (rst),
      .flush      (flush),
      .req_valid  (req_valid),
      .req_pc     (req_pc),
      .arready    (arready),
      .rdata      (rdata),
      .rvalid     (rvalid),
      .rlast      (rlast),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp_inst  (resp_inst),
      .resp_pc    (resp_pc),
      .araddr     (araddr),
      .arlen      (arlen),
      .arsize     (arsize),
      .arburst    (arburst),
      .arvalid    (arvalid),
      .rready     (rready)
   );

endmodule

//--- verif/mem_model.sv
module mem_model (
   input  logic        clk,
   input  logic        rst,
   input  logic [63:0] araddr,
   input  logic        arvalid,
   output logic        arready = 1'b0,
   output logic [63:0] rdata = '0,
   output logic        rvalid = 1'b0,
   output logic        rlast = 1'b0,
   input  logic        rready
);

   // burst in progress
   logic busy;
   logic [63:0] base;
   logic [1:0] beat;
   // random wait before the next arready or rvalid
   int unsigned wait_cnt;

   // instruction word at a byte address
   function automatic logic [31:0] word_at(input logic [63:0] addr);
      logic [61:0] n;
      logic [11:0] imm;
      n = addr[63:2];
      // whole word index folded into the addi immediate
      imm = n[11:0] ^ n[23:12] ^ n[35:24] ^ n[47:36] ^ n[59:48] ^ {10'd0, n[61:60]};
      case (n[3:0])
         4'd5:    return 32'h0100_006f;
         4'd9:    return 32'h0000_0663;
         4'd12:   return 32'hfe00_0ce3;
         default: return {imm, 20'h0_0013};
      endcase
   endfunction

   always @(posedge clk) begin
      if (rst) begin
         arready <= 1'b0;
         rvalid <= 1'b0;
         rlast <= 1'b0;
         busy <= 1'b0;
         beat <= 2'd0;
         wait_cnt <= 0;
      end else if (!busy) begin
         if (arvalid && arready) begin
            // address taken, data after a random gap
            arready <= 1'b0;
            busy <= 1'b1;
            base <= araddr;
            beat <= 2'd0;
            wait_cnt <= $urandom_range(4, 0);
         end else if (arvalid) begin
            if (wait_cnt == 0) begin
               arready <= 1'b1;
            end else begin
               wait_cnt <= wait_cnt - 1;
            end
         end
      end else if (rvalid && rready) begin
         rvalid <= 1'b0;
         rlast <= 1'b0;
         wait_cnt <= $urandom_range(3, 0);
         if (rlast) begin
            busy <= 1'b0;
         end else begin
            beat <= beat + 1'b1;
         end
      end else if (!rvalid) begin
         if (wait_cnt == 0) begin
            // little endian, lower word first
            rvalid <= 1'b1;
            rdata <= {word_at({base[63:5], beat, 3'b100}), word_at({base[63:5], beat, 3'b000})};
            rlast <= (beat == 2'd3);
         end else begin
            wait_cnt <= wait_cnt - 1;
         end
      end
   end

endmodule

//--- verif/fetch_tb.sv
module fetch_tb;

   localparam logic [63:0] start_pc = 64'h0000_0000_8000_0000;
   localparam int decode_depth = 2;
   localparam int redirect_count = 12;
   localparam int min_gap = 150;
   localparam int max_gap = 250;
   localparam int tail_cycles = 100;
   // reset plus every redirect gap at its longest plus the tail
   localparam int test_cycles = 3 + redirect_count * (max_gap + 1) + tail_cycles;
   localparam int watchdog_cycles = test_cycles + test_cycles / 4;
   // longest quiet spell with a free decode slot
   localparam int stall_limit = 100;

   logic clk = 1'b0;
   logic rst = 1'b1;
   logic redirect = 1'b0;
   logic [63:0] redirect_pc = '0;
   logic credit_return = 1'b0;
   logic inst_valid;
   logic [31:0] inst;
   logic [63:0] inst_pc;
   logic [63:0] araddr;
   logic [7:0] arlen;
   logic [2:0] arsize;
   logic [1:0] arburst;
   logic arvalid;
   logic arready;
   logic [63:0] rdata;
   logic rvalid;
   logic rlast;
   logic rready;

   // checker state
   logic [63:0] expect_pc;
   logic after_redirect;
   int decode_held;
   int idle_cycles;
   int delivered;
   int refills;
   // line address the cache should hold at each index
   logic [58:0] line_addr [16];
   logic [15:0] line_seen;
   // data phase of a burst is open
   logic in_burst;

   fetch_top i_fetch_top (
      .clk           (clk),
      .rst           (rst),
      .redirect      (redirect),
      .redirect_pc   (redirect_pc),
      .credit_return (credit_return),
      .inst_valid    (inst_valid),
      .inst          (inst),
      .inst_pc       (inst_pc),
      .araddr        (araddr),
      .arlen         (arlen),
      .arsize        (arsize),
      .arburst       (arburst),
      .arvalid       (arvalid),
      .arready       (arready),
      .rdata         (rdata),
      .rvalid        (rvalid),
      .rlast         (rlast),
      .rready        (rready)
   );

   mem_model i_mem_model (
      .clk     (clk),
      .rst     (rst),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rvalid  (rvalid),
      .rlast   (rlast),
      .rready  (rready)
   );

   initial begin
      forever #50 clk = ~clk;
   end

   // instruction word at a byte address
   function automatic logic [31:0] word_at(input logic [63:0] addr);
      logic [61:0] n;
      logic [11:0] imm;
      n = addr[63:2];
      imm = n[11:0] ^ n[23:12] ^ n[35:24] ^ n[47:36] ^ n[59:48] ^ {10'd0, n[61:60]};
      case (n[3:0])
         4'd5:    return 32'h0100_006f;
         4'd9:    return 32'h0000_0663;
         4'd12:   return 32'hfe00_0ce3;
         default: return {imm, 20'h0_0013};
      endcase
   endfunction

   // jal jumps +16, backward beq taken, forward beq falls through
   function automatic logic [63:0] next_pc(input logic [63:0] pc);
      case (pc[5:2])
         4'd5:    return pc + 64'd16;
         4'd12:   return pc - 64'd8;
         default: return pc + 64'd4;
      endcase
   endfunction

   task automatic report_mismatch(input string test, input logic [63:0] expected,
                                  input logic [63:0] actual);
      $display("Mismatch in %s: expected %h, actual %h", test, expected, actual);
      $display("Errors found");
      $fatal(1, "%s check failed", test);
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Errors found");
      $fatal(1, "check failed");
   endtask

   // reset then redirects at random gaps into a 1 KB window
   initial begin
      logic [63:0] target;
      void'($urandom(32'h01c3_d0f6));
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < redirect_count; i++) begin
         repeat ($urandom_range(max_gap, min_gap)) @(posedge clk);
         target = start_pc + (64'($urandom_range(255, 0)) << 2);
         redirect <= 1'b1;
         redirect_pc <= target;
         @(posedge clk);
         redirect <= 1'b0;
      end
      repeat (tail_cycles) @(posedge clk);
      if (delivered <= redirect_count) begin
         report_failure("too few instructions delivered");
      end else if (refills <= 1) begin
         report_failure("too few line refills");
      end else begin
         $display("No errors");
         $finish;
      end
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles", watchdog_cycles);
      $display("Errors found");
      $fatal(1, "timeout");
   end

   // decode buffer frees one slot at a time after a random delay
   always @(posedge clk) begin
      int held_now;
      if (rst) begin
         decode_held <= 0;
         credit_return <= 1'b0;
      end else begin
         held_now = decode_held + (inst_valid ? 1 : 0) - (credit_return ? 1 : 0);
         decode_held <= held_now;
         credit_return <= (held_now > 0) && ($urandom_range(3, 0) == 0);
      end
   end

   always @(posedge clk) begin
      if (rst) begin
         expect_pc <= start_pc;
         after_redirect <= 1'b0;
         idle_cycles <= 0;
         delivered <= 0;
         refills <= 0;
         line_seen <= '0;
         in_burst <= 1'b0;
      end else begin
         if (redirect) begin
            // nothing from the old path may slip through
            assert (!inst_valid) else report_failure("instruction delivered during redirect");
            expect_pc <= redirect_pc;
            after_redirect <= 1'b1;
         end else if (inst_valid) begin
            assert (decode_held < decode_depth)
               else report_failure("instruction delivered with no decode credit");
            assert (inst_pc == expect_pc)
               else report_mismatch(after_redirect ? "redirect target" : "predicted pc",
                                    expect_pc, inst_pc);
            assert (inst == word_at(inst_pc))
               else report_mismatch("instruction word", 64'(word_at(inst_pc)), 64'(inst));
            expect_pc <= next_pc(inst_pc);
            after_redirect <= 1'b0;
            delivered <= delivered + 1;
         end

         // fetch must come back once a slot is free
         if (inst_valid || redirect || decode_held == decode_depth) begin
            idle_cycles <= 0;
         end else begin
            idle_cycles <= idle_cycles + 1;
         end
         assert (idle_cycles < stall_limit)
            else report_failure("fetch did not resume with free decode credits");

         // burst shape and line reuse
         if (arvalid && arready) begin
            assert (araddr[4:0] == 5'd0)
               else report_mismatch("araddr alignment", 64'd0, 64'(araddr[4:0]));
            assert (arlen == 8'd3) else report_mismatch("arlen", 64'd3, 64'(arlen));
            assert (arsize == 3'd3) else report_mismatch("arsize", 64'd3, 64'(arsize));
            assert (arburst == 2'd1) else report_mismatch("arburst", 64'd1, 64'(arburst));
            assert (!(line_seen[araddr[8:5]] && line_addr[araddr[8:5]] == araddr[63:5]))
               else report_failure("cached line requested again");
            line_seen[araddr[8:5]] <= 1'b1;
            line_addr[araddr[8:5]] <= araddr[63:5];
            refills <= refills + 1;
            in_burst <= 1'b1;
         end
         if (rvalid && rready && rlast) begin
            in_burst <= 1'b0;
         end

         // data phase opens at the address handshake and closes at rlast
         assert (rready == in_burst)
            else report_mismatch("rready", 64'(in_burst), 64'(rready));
         assert (!(arvalid && in_burst)) else report_failure("arvalid raised during a data burst");
      end
   end

endmodule

//--- filelist.f
verilog/fetch_pkg.sv
verilog/fetch_unit.sv
verilog/icache.sv
verilog/fetch_top.sv
verif/mem_model.sv
verif/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module fetch_tb -o fetch_sim

# the log decides the result
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
